/* cache_top.f */
rtl/cache_pkg.sv
rtl/cache_stage_if.sv
rtl/cache_req_reg.sv
rtl/cache_lookup.sv
rtl/cache_miss_ctrl.sv
rtl/cache_top.sv
testbench/tb_mem_model.sv
testbench/cache_tb.sv

/* rtl/cache_lookup.sv */
`default_nettype none

module cache_lookup (
    input  wire                         clk,
    input  wire                         rst_n,
    stage_req_if.sink                   in,
    miss_if.requester                   miss,
    output logic                        rsp_valid,
    output logic [cache_pkg::ADDR_W-1:0] rsp_rdata
);

    // --------------------
    // Way arrays
    // --------------------

    // Tag and data per way and set, combinational read
    logic [cache_pkg::TAG_W-1:0]  tag_q  [cache_pkg::WAYS][cache_pkg::SETS];
    logic [cache_pkg::ADDR_W-1:0] data_q [cache_pkg::WAYS][cache_pkg::SETS];
    // Line state bits
    logic [cache_pkg::WAYS-1:0][cache_pkg::SETS-1:0] valid_q;
    logic [cache_pkg::WAYS-1:0][cache_pkg::SETS-1:0] dirty_q;
    // Way to evict next, one bit per set
    logic [cache_pkg::SETS-1:0] lru_q;

    // Decoded request address
    cache_pkg::cache_addr_u        req_addr;
    logic [cache_pkg::TAG_W-1:0]   tag;
    logic [cache_pkg::INDEX_W-1:0] set;

    // Rebuilt memory addresses
    cache_pkg::cache_addr_u victim_addr_u;
    cache_pkg::cache_addr_u fill_addr_u;

    logic [cache_pkg::WAYS-1:0] way_hit;
    logic hit;
    logic hit_way;
    logic victim_way;
    logic hit_access;
    logic lookup_miss;
    logic fill_now;
    logic acc_way;
    logic waiting;
    logic fill_way;

    assign req_addr = in.addr;
    assign tag      = req_addr.fields.tag;
    assign set      = req_addr.fields.index;

    // Tag compare in both ways
    always_comb begin
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            way_hit[w] = valid_q[w][set] && (tag_q[w][set] == tag);
        end
    end

    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];
    assign victim_way = lru_q[set];

    // New request hits, or misses and must go to memory
    assign hit_access  = in.valid && hit && !waiting;
    assign lookup_miss = in.valid && !hit && !waiting;
    // Refill returns, line installed at this edge
    assign fill_now    = waiting && miss.done;
    // Way being touched by a hit or a fill
    assign acc_way     = waiting ? fill_way : hit_way;

    // Stall from miss detection up to the cycle of done
    assign in.hold = lookup_miss || (waiting && !miss.done);

    // Victim address from the stored tag, fill address from the request
    always_comb begin
        victim_addr_u              = '0;
        victim_addr_u.fields.tag   = tag_q[victim_way][set];
        victim_addr_u.fields.index = set;
        fill_addr_u                = req_addr;
        fill_addr_u.fields.offset  = '0;
    end

    // --------------------
    // Array updates
    // --------------------

    always_ff @(posedge clk) begin
        if (hit_access && in.we) begin
            data_q[hit_way][set] <= in.wdata;
        end
        if (fill_now) begin
            tag_q[fill_way][set]  <= tag;
            // Write miss keeps the new word, read miss keeps memory data
            data_q[fill_way][set] <= in.we ? in.wdata : miss.fill_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
            waiting <= 1'b0;
        end else begin
            // Accessed way becomes most recently used
            if (hit_access || fill_now) begin
                lru_q[set] <= !acc_way;
            end
            if (hit_access && in.we) begin
                dirty_q[hit_way][set] <= 1'b1;
            end
            if (fill_now) begin
                valid_q[fill_way][set] <= 1'b1;
                dirty_q[fill_way][set] <= in.we;
            end
            if (lookup_miss) begin
                waiting <= 1'b1;
            end else if (fill_now) begin
                waiting <= 1'b0;
            end
        end
    end

    // --------------------
    // Miss hand-off
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            miss.start <= 1'b0;
        end else begin
            miss.start <= lookup_miss;
        end
    end

    // Victim details frozen for the whole miss
    always_ff @(posedge clk) begin
        if (lookup_miss) begin
            fill_way         <= victim_way;
            miss.dirty       <= valid_q[victim_way][set] && dirty_q[victim_way][set];
            miss.victim_addr <= victim_addr_u.raw;
            miss.victim_data <= data_q[victim_way][set];
            miss.fill_addr   <= fill_addr_u.raw;
        end
    end

    // --------------------
    // Response register
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= hit_access || fill_now;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_access) begin
            rsp_rdata <= data_q[hit_way][set];
        end else if (fill_now) begin
            rsp_rdata <= miss.fill_data;
        end
    end

    // Fills never leave the same tag in both ways
    a_single_way_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        in.valid |-> $onehot0(way_hit)
    );

    // Miss controller only completes a miss this stage started
    a_done_while_waiting: assert property (
        @(posedge clk) disable iff (!rst_n)
        miss.done |-> waiting
    );

endmodule

`default_nettype wire

/* rtl/cache_miss_ctrl.sv */
`default_nettype none

module cache_miss_ctrl (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         mem_ack,
    input  wire [cache_pkg::ADDR_W-1:0] mem_rdata,
    miss_if.responder                   miss,
    output logic                        mem_req,
    output logic                        mem_we,
    output logic [cache_pkg::ADDR_W-1:0] mem_addr,
    output logic [cache_pkg::ADDR_W-1:0] mem_wdata
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WB_REQ,
        S_WB_WAIT,
        S_RF_REQ,
        S_RF_WAIT
    } state_t;

    state_t state;
    state_t state_nxt;

    // Memory access issued and not yet acked
    logic outstanding;

    // --------------------
    // Next state
    // --------------------

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                // Dirty victim goes out before the refill
                if (miss.start) begin
                    state_nxt = miss.dirty ? S_WB_REQ : S_RF_REQ;
                end
            end
            S_WB_REQ:  state_nxt = S_WB_WAIT;
            S_WB_WAIT: begin
                if (mem_ack) begin
                    state_nxt = S_RF_REQ;
                end
            end
            S_RF_REQ:  state_nxt = S_RF_WAIT;
            S_RF_WAIT: begin
                if (mem_ack) begin
                    state_nxt = S_IDLE;
                end
            end
            default:   state_nxt = S_IDLE;
        endcase
    end

    // Single-cycle request strobes
    assign mem_req   = (state == S_WB_REQ) || (state == S_RF_REQ);
    assign mem_we    = (state == S_WB_REQ);
    assign mem_addr  = mem_we ? miss.victim_addr : miss.fill_addr;
    assign mem_wdata = miss.victim_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            miss.done <= 1'b0;
        end else begin
            state     <= state_nxt;
            // Done one cycle after the refill ack
            miss.done <= (state == S_RF_WAIT) && mem_ack;
        end
    end

    // Refill word handed back with done
    always_ff @(posedge clk) begin
        if ((state == S_RF_WAIT) && mem_ack) begin
            miss.fill_data <= mem_rdata;
        end
    end

    // --------------------
    // Access tracking
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (mem_req) begin
            outstanding <= 1'b1;
        end else if (mem_ack) begin
            outstanding <= 1'b0;
        end
    end

    // One memory access at a time
    a_one_outstanding: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req |-> !outstanding
    );

endmodule

`default_nettype wire

/* rtl/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // --------------------
    // Cache geometry
    // --------------------

    // Address and data word width
    localparam int ADDR_W = 32;

    // One word per line, so only the byte offset sits below the index
    localparam int OFFSET_W = 2;

    // Small set count so that evictions are easy to provoke
    localparam int SETS = 16;
    localparam int INDEX_W = $clog2(SETS);

    // Two ways, one LRU bit per set
    localparam int WAYS = 2;

    // Whatever is left above index and offset
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    // --------------------
    // Address views
    // --------------------

    // Same 32 bits seen as a plain word or split into fields
    // Lookup splits the request address
    // Victim and fill addresses are rebuilt from the fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            // Upper bits compared against the stored tag
            logic [TAG_W-1:0]    tag;
            // Selects the set in every array
            logic [INDEX_W-1:0]  index;
            // Byte within the word, zero for memory accesses
            logic [OFFSET_W-1:0] offset;
        } fields;
    } cache_addr_u;

endpackage

`default_nettype wire

/* rtl/cache_req_reg.sv */
`default_nettype none

module cache_req_reg (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         req,
    input  wire                         req_we,
    input  wire [cache_pkg::ADDR_W-1:0] req_addr,
    input  wire [cache_pkg::ADDR_W-1:0] req_wdata,
    output logic                        ready,
    stage_req_if.source                 out
);

    // Request accepted this cycle
    logic take;

    // Back-pressure only while the lookup stage is busy with a miss
    assign ready = !out.hold;
    assign take  = req && ready;

    // --------------------
    // Valid bit
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else if (!out.hold) begin
            // Entry moves on every free cycle, empty if nothing came in
            out.valid <= req;
        end
    end

    // --------------------
    // Payload
    // --------------------

    always_ff @(posedge clk) begin
        if (take) begin
            out.we    <= req_we;
            out.addr  <= req_addr;
            out.wdata <= req_wdata;
        end
    end

    // Stalled request leaves the held entry untouched
    a_held_entry_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req && !ready) |=> (out.valid && $stable(out.we)
                             && $stable(out.addr) && $stable(out.wdata))
    );

endmodule

`default_nettype wire

/* rtl/cache_stage_if.sv */
`default_nettype none

// --------------------
// Request register to lookup
// --------------------

interface stage_req_if;
    // Entry present in the request register
    logic                         valid;
    // Write flag and payload of the entry
    logic                         we;
    logic [cache_pkg::ADDR_W-1:0] addr;
    logic [cache_pkg::ADDR_W-1:0] wdata;
    // Lookup busy with a miss, entry must stay put
    logic                         hold;

    modport source (output valid, output we, output addr, output wdata, input hold);
    modport sink   (input valid, input we, input addr, input wdata, output hold);
endinterface

// --------------------
// Lookup to miss controller
// --------------------

interface miss_if;
    // One-cycle kick for a new miss
    logic                         start;
    // Victim line needs a write-back first
    logic                         dirty;
    logic [cache_pkg::ADDR_W-1:0] victim_addr;
    logic [cache_pkg::ADDR_W-1:0] victim_data;
    // Word address of the missing line
    logic [cache_pkg::ADDR_W-1:0] fill_addr;
    // One-cycle completion, fill_data valid with it
    logic                         done;
    logic [cache_pkg::ADDR_W-1:0] fill_data;

    modport requester (
        output start, output dirty, output victim_addr, output victim_data,
        output fill_addr, input done, input fill_data
    );
    modport responder (
        input start, input dirty, input victim_addr, input victim_data,
        input fill_addr, output done, output fill_data
    );
endinterface

`default_nettype wire

/* rtl/cache_top.sv */
`default_nettype none

module cache_top (
    input  wire                         clk,
    input  wire                         rst_n,

    // Processor side
    input  wire                         req,
    input  wire                         req_we,
    input  wire [cache_pkg::ADDR_W-1:0] req_addr,
    input  wire [cache_pkg::ADDR_W-1:0] req_wdata,
    output logic                        ready,
    output logic                        rsp_valid,
    output logic [cache_pkg::ADDR_W-1:0] rsp_rdata,

    // Memory side
    output logic                        mem_req,
    output logic                        mem_we,
    output logic [cache_pkg::ADDR_W-1:0] mem_addr,
    output logic [cache_pkg::ADDR_W-1:0] mem_wdata,
    input  wire                         mem_ack,
    input  wire [cache_pkg::ADDR_W-1:0] mem_rdata
);

    // --------------------
    // Stage links
    // --------------------

    stage_req_if stage_req ();
    miss_if      miss ();

    // Stage one, captures the processor request
    cache_req_reg cache_req_reg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_we    (req_we),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .ready     (ready),
        .out       (stage_req.source)
    );

    // Stage two, arrays and response
    cache_lookup cache_lookup_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (stage_req.sink),
        .miss      (miss.requester),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata)
    );

    // Write-back and refill toward memory
    cache_miss_ctrl cache_miss_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .miss      (miss.responder),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it, then judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
    -f cache_top.f -o cache_sim \
    && ./obj_dir/cache_sim 2>&1 | tee sim.log \
    || { echo "build or simulation error"; exit 1; }
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* testbench/cache_tb.sv */
`default_nettype none

module cache_tb;

    localparam int ACCEPT_LIMIT = 200;
    localparam int DRAIN_LIMIT  = 1000;
    localparam int RANDOM_OPS   = 300;

    // Three tags in set 3, enough to force evictions
    localparam logic [31:0] ADDR_A = {26'd1, 4'd3, 2'b00};
    localparam logic [31:0] ADDR_B = {26'd2, 4'd3, 2'b00};
    localparam logic [31:0] ADDR_C = {26'd3, 4'd3, 2'b00};

    // Expected response of one accepted request
    typedef struct packed {
        logic        hit;
        logic        we;
        logic [31:0] rdata;
        logic [31:0] cycle;
    } rsp_t;

    // Expected memory access, write-back or refill
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] data;
    } mem_acc_t;

    logic        clk;
    logic        rst_n;
    logic        req;
    logic        req_we;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic        ready;
    logic        rsp_valid;
    logic [31:0] rsp_rdata;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_ack;
    logic [31:0] mem_rdata;

    rsp_t     rsp_exp_q [$];
    mem_acc_t mem_exp_q [$];

    // Reference cache: tags, state bits and a flat image of memory
    logic [25:0] m_tag   [2][16];
    logic        m_valid [2][16];
    logic        m_dirty [2][16];
    logic        m_lru   [16];
    logic [31:0] image   [logic [31:0]];

    logic [31:0] cycle;
    logic [31:0] last_accept;
    logic        prev_hit;
    logic        timed_out;
    int          checks;
    int          errors;

    cache_top cache_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_we    (req_we),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .ready     (ready),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    tb_mem_model mem_model_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Edge counter for latency checks
    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    // --------------------
    // Reference model
    // --------------------

    // Same fill rule as the memory model
    function automatic logic [31:0] image_word(input logic [31:0] addr);
        if (image.exists(addr)) begin
            return image[addr];
        end
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h6b3a_19c5;
    endfunction

    // Applies one access to the model, queues the memory traffic it implies
    function automatic rsp_t predict_access(input logic we, input logic [31:0] addr,
                                            input logic [31:0] wdata);
        rsp_t        r;
        mem_acc_t    m;
        logic [3:0]  idx;
        logic [25:0] tg;
        logic        way;
        idx   = addr[5:2];
        tg    = addr[31:6];
        r     = '0;
        r.we  = we;
        r.hit = 1'b1;
        if (m_valid[0][idx] && m_tag[0][idx] == tg) begin
            way = 1'b0;
        end else if (m_valid[1][idx] && m_tag[1][idx] == tg) begin
            way = 1'b1;
        end else begin
            // Miss, LRU way is the victim
            r.hit = 1'b0;
            way   = m_lru[idx];
            if (m_valid[way][idx] && m_dirty[way][idx]) begin
                m.we   = 1'b1;
                m.addr = {m_tag[way][idx], idx, 2'b00};
                m.data = image_word(m.addr);
                mem_exp_q.push_back(m);
            end
            // Then exactly one refill read
            m.we   = 1'b0;
            m.addr = addr;
            m.data = '0;
            mem_exp_q.push_back(m);
            m_tag[way][idx]   = tg;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
        end
        if (we) begin
            image[addr]       = wdata;
            m_dirty[way][idx] = 1'b1;
        end
        r.rdata    = image_word(addr);
        m_lru[idx] = !way;
        return r;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------

    // Holds req until accepted, then predicts the outcome
    task automatic issue_request(input logic we, input logic [31:0] addr,
                                 input logic [31:0] wdata);
        rsp_t r;
        logic accepted;
        int   waited;
        if (!timed_out) begin
            req       = 1'b1;
            req_we    = we;
            req_addr  = addr;
            req_wdata = wdata;
            accepted  = 1'b0;
            waited    = 0;
            while (!accepted && waited < ACCEPT_LIMIT) begin
                @(posedge clk);
                accepted = ready;
                waited++;
            end
            if (!accepted) begin
                timed_out = 1'b1;
                $display("timeout: request to address %h was never accepted", addr);
            end else begin
                r       = predict_access(we, addr, wdata);
                r.cycle = cycle;
                // A hit never stalls the request behind it
                if (prev_hit) begin
                    compare_value("accept cycle", cycle, last_accept + 32'd1);
                end
                prev_hit    = r.hit;
                last_accept = cycle;
                rsp_exp_q.push_back(r);
            end
            #1;
            req = 1'b0;
        end
    endtask

    initial begin
        logic        we;
        logic [31:0] addr;
        int          waited;
        void'($urandom(32'h33f1_b103));
        rst_n       = 1'b0;
        req         = 1'b0;
        req_we      = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        cycle       = '0;
        last_accept = '0;
        prev_hit    = 1'b0;
        timed_out   = 1'b0;
        checks      = 0;
        errors      = 0;
        for (int s = 0; s < 16; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_dirty[0][s] = 1'b0;
            m_dirty[1][s] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Idle outputs straight out of reset
        compare_value("ready", 32'(ready), 32'd1);
        compare_value("rsp_valid", 32'(rsp_valid), 32'd0);
        compare_value("mem_req", 32'(mem_req), 32'd0);

        // Cold misses, write hit, clean and dirty evictions, refetch
        issue_request(1'b0, ADDR_A, '0);
        issue_request(1'b0, ADDR_B, '0);
        issue_request(1'b1, ADDR_A, 32'hdead_0001);
        issue_request(1'b0, ADDR_C, '0);
        issue_request(1'b0, ADDR_B, '0);
        issue_request(1'b0, ADDR_A, '0);

        // Back-to-back hits on the two resident lines
        for (int i = 0; i < 8; i++) begin
            issue_request(1'b0, ADDR_A, '0);
            issue_request(i[0], ADDR_B, 32'h5eed_0000 ^ 32'(i));
        end

        // Random mix over 4 sets and 6 tags
        for (int i = 0; i < RANDOM_OPS; i++) begin
            we   = ($urandom % 3) == 0;
            addr = {26'($urandom % 6), 4'($urandom % 4), 2'b00};
            issue_request(we, addr, $urandom);
        end

        // Drain outstanding responses and memory traffic
        waited = 0;
        while (!timed_out && (rsp_exp_q.size() != 0 || mem_exp_q.size() != 0)
               && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!timed_out && (rsp_exp_q.size() != 0 || mem_exp_q.size() != 0)) begin
            timed_out = 1'b1;
            $display("timeout: %0d responses and %0d memory accesses never arrived",
                     rsp_exp_q.size(), mem_exp_q.size());
        end
        // Short quiet window for stray strobes
        repeat (10) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (!timed_out && errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // --------------------
    // Comparison
    // --------------------

    // Responses in request order, rdata for reads, latency for hits
    always @(posedge clk) begin
        rsp_t e;
        if (rst_n && rsp_valid) begin
            if (rsp_exp_q.size() == 0) begin
                errors++;
                $display("response arrived with no request outstanding");
            end else begin
                e = rsp_exp_q.pop_front();
                if (!e.we) begin
                    compare_value("rsp_rdata", rsp_rdata, e.rdata);
                end
                if (e.hit) begin
                    compare_value("hit latency", cycle - e.cycle, 32'd2);
                end
            end
        end
    end

    // Every memory access must be a predicted write-back or refill
    always @(posedge clk) begin
        mem_acc_t m;
        if (rst_n && mem_req) begin
            if (mem_exp_q.size() == 0) begin
                errors++;
                $display("memory access to %h with no miss pending", mem_addr);
            end else begin
                m = mem_exp_q.pop_front();
                compare_value("mem_we", 32'(mem_we), 32'(m.we));
                compare_value("mem_addr", mem_addr, m.addr);
                if (m.we) begin
                    compare_value("mem_wdata", mem_wdata, m.data);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_mem_model.sv */
`default_nettype none

module tb_mem_model (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         mem_req,
    input  wire         mem_we,
    input  wire  [31:0] mem_addr,
    input  wire  [31:0] mem_wdata,
    output logic        mem_ack,
    output logic [31:0] mem_rdata
);

    // Log of every write-back, keyed by word address
    logic [31:0] written [logic [31:0]];

    // Contents of a word nobody has written yet
    function automatic logic [31:0] initial_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h6b3a_19c5;
    endfunction

    function automatic logic [31:0] stored_word(input logic [31:0] addr);
        if (written.exists(addr)) begin
            return written[addr];
        end
        return initial_word(addr);
    endfunction

    // --------------------
    // Access server
    // --------------------

    initial begin
        logic [31:0] addr;
        int unsigned latency;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            if (rst_n && mem_req) begin
                addr = mem_addr;
                // Write lands at once, only the ack is delayed
                if (mem_we) begin
                    written[addr] = mem_wdata;
                end
                // 1 to 4 cycles until the ack
                latency = 1 + ($urandom % 4);
                repeat (latency - 1) @(posedge clk);
                #1;
                mem_ack   = 1'b1;
                mem_rdata = stored_word(addr);
                @(posedge clk);
                #1;
                mem_ack = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire
